/* Bender.yml */
package:
  name: pipe_core

sources:
  - src/pipePkg.sv
  - src/regFile.sv
  - src/decodeStage.sv
  - src/hazardUnit.sv
  - src/executeStage.sv
  - src/memStage.sv
  - src/pipeTop.sv
  - target: test
    files:
      - tests/pipeTb.sv

/* all.f */
src/pipePkg.sv
src/regFile.sv
src/decodeStage.sv
src/hazardUnit.sv
src/executeStage.sv
src/memStage.sv
src/pipeTop.sv
tests/pipeTb.sv

/* src/decodeStage.sv */
`timescale 1ns/1ns

module decodeStage (
	input  logic              clk,
	input  logic              reset,
	input  logic              instrValid,
	input  pipePkg::word_t    instr,
	input  logic              stall,
	output pipePkg::regAddr_t srcA,
	output pipePkg::regAddr_t srcB,
	output pipePkg::tick_t    tuseA,
	output pipePkg::tick_t    tuseB,
	input  logic              wbEnable,
	input  pipePkg::regAddr_t wbAddr,
	input  pipePkg::word_t    wbData,
	output pipePkg::kind_t    deKind,
	output pipePkg::regAddr_t deRs,
	output pipePkg::regAddr_t deRt,
	output pipePkg::regAddr_t deWriteAddr,
	output logic [4:0]        deShamt,
	output pipePkg::word_t    deImm,
	output pipePkg::word_t    deDataA,
	output pipePkg::word_t    deDataB,
	output pipePkg::word_t    deEarly,
	output pipePkg::tick_t    deTuseA,
	output pipePkg::tick_t    deTuseB,
	output pipePkg::tick_t    deTnew
);

	pipePkg::kind_t kind;
	pipePkg::regAddr_t writeAddr;
	pipePkg::tick_t tnew;
	pipePkg::word_t imm;
	pipePkg::word_t rfDataA;
	pipePkg::word_t rfDataB;
	logic bubble;

	assign srcA = instr[25:21];
	assign srcB = instr[20:16];
	assign bubble = !instrValid || stall;

	regFile u_regFile (
		.clk(clk),
		.reset(reset),
		.readAddrA(srcA),
		.readAddrB(srcB),
		.readDataA(rfDataA),
		.readDataB(rfDataB),
		.writeEnable(wbEnable),
		.writeAddr(wbAddr),
		.writeData(wbData)
	);

	////////////////////
	// Opcode decode
	////////////////////
	always_comb
	begin
		kind = pipePkg::kindNop;
		case (instr[31:26])
			pipePkg::opSpecial:
			begin
				case (instr[5:0])
					pipePkg::fnAddu: kind = pipePkg::kindAddu;
					pipePkg::fnSubu: kind = pipePkg::kindSubu;
					pipePkg::fnAnd:  kind = pipePkg::kindAnd;
					pipePkg::fnOr:   kind = pipePkg::kindOr;
					pipePkg::fnXor:  kind = pipePkg::kindXor;
					pipePkg::fnSlt:  kind = pipePkg::kindSlt;
					pipePkg::fnSll:  kind = pipePkg::kindSll;
					default:         kind = pipePkg::kindNop;
				endcase
			end
			pipePkg::opAddiu: kind = pipePkg::kindAddiu;
			pipePkg::opAndi:  kind = pipePkg::kindAndi;
			pipePkg::opOri:   kind = pipePkg::kindOri;
			pipePkg::opLui:   kind = pipePkg::kindLui;
			pipePkg::opLw:    kind = pipePkg::kindLw;
			pipePkg::opSw:    kind = pipePkg::kindSw;
			default:          kind = pipePkg::kindNop;
		endcase
		// Nothing offered counts as a no-op, so it never stalls
		if (!instrValid)
			kind = pipePkg::kindNop;
	end

	// Destination, immediate and counters per kind
	always_comb
	begin
		writeAddr = '0;
		tuseA = pipePkg::tuseNone;
		tuseB = pipePkg::tuseNone;
		tnew = pipePkg::tnewNone;
		imm = {{16{instr[15]}}, instr[15:0]};
		case (kind)
			pipePkg::kindAddu, pipePkg::kindSubu, pipePkg::kindAnd,
			pipePkg::kindOr, pipePkg::kindXor, pipePkg::kindSlt:
			begin
				writeAddr = instr[15:11];
				tuseA = pipePkg::tuseEx;
				tuseB = pipePkg::tuseEx;
				tnew = pipePkg::tnewAlu;
			end
			pipePkg::kindSll:
			begin
				writeAddr = instr[15:11];
				tuseB = pipePkg::tuseEx;
				tnew = pipePkg::tnewAlu;
			end
			pipePkg::kindAddiu:
			begin
				writeAddr = instr[20:16];
				tuseA = pipePkg::tuseEx;
				tnew = pipePkg::tnewAlu;
			end
			pipePkg::kindAndi, pipePkg::kindOri:
			begin
				writeAddr = instr[20:16];
				tuseA = pipePkg::tuseEx;
				tnew = pipePkg::tnewAlu;
				imm = {16'h0000, instr[15:0]};
			end
			pipePkg::kindLui:
			begin
				writeAddr = instr[20:16];
				tnew = pipePkg::tnewAlu;
			end
			pipePkg::kindLw:
			begin
				writeAddr = instr[20:16];
				tuseA = pipePkg::tuseEx;
				tnew = pipePkg::tnewLoad;
			end
			// Store data is consumed in execute like an ALU source
			pipePkg::kindSw:
			begin
				tuseA = pipePkg::tuseEx;
				tuseB = pipePkg::tuseEx;
			end
			default:
			begin
				writeAddr = '0;
			end
		endcase
	end

	////////////////////
	// Decode to execute
	////////////////////
	always_ff @(posedge clk)
	begin
		if (reset || bubble)
		begin
			deKind <= pipePkg::kindNop;
			deRs <= '0;
			deRt <= '0;
			deWriteAddr <= '0;
			deTuseA <= pipePkg::tuseNone;
			deTuseB <= pipePkg::tuseNone;
			deTnew <= pipePkg::tnewNone;
		end
		else
		begin
			deKind <= kind;
			deRs <= srcA;
			deRt <= srcB;
			deWriteAddr <= writeAddr;
			deTuseA <= tuseA;
			deTuseB <= tuseB;
			deTnew <= tnew;
		end
	end

	always_ff @(posedge clk)
	begin
		deShamt <= instr[10:6];
		deImm <= imm;
		deDataA <= rfDataA;
		deDataB <= rfDataB;
		// lui result is known here already
		deEarly <= {instr[15:0], 16'h0000};
	end

endmodule

/* src/executeStage.sv */
`timescale 1ns/1ns

module executeStage (
	input  logic              clk,
	input  logic              reset,
	input  pipePkg::kind_t    deKind,
	input  pipePkg::regAddr_t deRs,
	input  pipePkg::regAddr_t deRt,
	input  pipePkg::regAddr_t deWriteAddr,
	input  logic [4:0]        deShamt,
	input  pipePkg::word_t    deImm,
	input  pipePkg::word_t    deDataA,
	input  pipePkg::word_t    deDataB,
	input  pipePkg::word_t    deEarly,
	input  pipePkg::tick_t    deTuseA,
	input  pipePkg::tick_t    deTuseB,
	input  pipePkg::tick_t    deTnew,
	input  pipePkg::bypass_t  bypassA,
	input  pipePkg::bypass_t  bypassB,
	input  pipePkg::bypass_t  bypassStore,
	input  pipePkg::word_t    wbData,
	output pipePkg::kind_t    emKind,
	output pipePkg::regAddr_t emWriteAddr,
	output pipePkg::word_t    emResult,
	output pipePkg::word_t    emStoreData,
	output pipePkg::tick_t    emTnew
);

	pipePkg::word_t opA;
	pipePkg::word_t opB;
	pipePkg::word_t storeData;
	pipePkg::word_t aluB;
	pipePkg::word_t result;
	pipePkg::tick_t tnewNext;
	logic useImm;
	logic lessThan;

	// Unused operands and register zero are held at zero
	function automatic pipePkg::word_t pickOperand(
		input pipePkg::bypass_t sel,
		input pipePkg::regAddr_t addr,
		input pipePkg::tick_t tuse,
		input pipePkg::word_t regValue,
		input pipePkg::word_t exValue,
		input pipePkg::word_t memValue
	);
		pipePkg::word_t value;
		if (tuse == pipePkg::tuseNone || addr == '0)
			value = '0;
		else
		begin
			case (sel)
				pipePkg::bypassEx:  value = exValue;
				pipePkg::bypassMem: value = memValue;
				default:            value = regValue;
			endcase
		end
		return value;
	endfunction

	////////////////////
	// Operand forwarding
	////////////////////
	assign opA = pickOperand(bypassA, deRs, deTuseA, deDataA, emResult, wbData);
	assign opB = pickOperand(bypassB, deRt, deTuseB, deDataB, emResult, wbData);
	// Separate select so store data never depends on the ALU input mux
	assign storeData = pickOperand(bypassStore, deRt, deTuseB, deDataB, emResult, wbData);

	assign useImm = (deKind == pipePkg::kindAddiu) || (deKind == pipePkg::kindAndi) ||
		(deKind == pipePkg::kindOri) || (deKind == pipePkg::kindLw) ||
		(deKind == pipePkg::kindSw);
	assign aluB = useImm ? deImm : opB;
	assign lessThan = $signed(opA) < $signed(aluB);

	////////////////////
	// ALU
	////////////////////
	always_comb
	begin
		case (deKind)
			pipePkg::kindAddu, pipePkg::kindAddiu,
			pipePkg::kindLw, pipePkg::kindSw:     result = opA + aluB;
			pipePkg::kindSubu:                    result = opA - aluB;
			pipePkg::kindAnd, pipePkg::kindAndi:  result = opA & aluB;
			pipePkg::kindOr, pipePkg::kindOri:    result = opA | aluB;
			pipePkg::kindXor:                     result = opA ^ aluB;
			pipePkg::kindSlt:                     result = {31'd0, lessThan};
			pipePkg::kindSll:                     result = opB << deShamt;
			pipePkg::kindLui:                     result = deEarly;
			default:                              result = '0;
		endcase
	end

	// One stage closer to a ready result
	assign tnewNext = (deTnew != pipePkg::tnewNone) ? deTnew - 3'd1 : deTnew;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			emKind <= pipePkg::kindNop;
			emWriteAddr <= '0;
			emTnew <= pipePkg::tnewNone;
		end
		else
		begin
			emKind <= deKind;
			emWriteAddr <= deWriteAddr;
			emTnew <= tnewNext;
		end
	end

	always_ff @(posedge clk)
	begin
		emResult <= result;
		emStoreData <= storeData;
	end

endmodule

/* src/hazardUnit.sv */
`timescale 1ns/1ns

module hazardUnit (
	input  pipePkg::regAddr_t srcA,
	input  pipePkg::regAddr_t srcB,
	input  pipePkg::tick_t    tuseA,
	input  pipePkg::tick_t    tuseB,
	input  pipePkg::regAddr_t deRs,
	input  pipePkg::regAddr_t deRt,
	input  pipePkg::regAddr_t deWriteAddr,
	input  pipePkg::tick_t    deTnew,
	input  pipePkg::regAddr_t emWriteAddr,
	input  pipePkg::tick_t    emTnew,
	input  logic              wbValid,
	input  pipePkg::regAddr_t wbAddr,
	output logic              stall,
	output pipePkg::bypass_t  bypassA,
	output pipePkg::bypass_t  bypassB,
	output pipePkg::bypass_t  bypassStore
);

	////////////////////
	// Load-use stall
	////////////////////

	// Producer one stage ahead is still too late for this source
	function automatic logic tooEarly(
		input pipePkg::regAddr_t src,
		input pipePkg::tick_t tuse,
		input pipePkg::regAddr_t dest,
		input pipePkg::tick_t tnew
	);
		return (dest != '0) && (src == dest) && (tuse < tnew);
	endfunction

	assign stall = tooEarly(srcA, tuseA, deWriteAddr, deTnew) ||
		tooEarly(srcB, tuseB, deWriteAddr, deTnew);

	////////////////////
	// Forwarding selects
	////////////////////

	// Newer stage first and em only once its value is final
	function automatic pipePkg::bypass_t pickSource(
		input pipePkg::regAddr_t src,
		input pipePkg::regAddr_t exAddr,
		input pipePkg::tick_t exTnew,
		input logic memValid,
		input pipePkg::regAddr_t memAddr
	);
		pipePkg::bypass_t sel;
		if (exAddr != '0 && exAddr == src && exTnew == pipePkg::tnewNone)
			sel = pipePkg::bypassEx;
		else if (memValid && memAddr == src)
			sel = pipePkg::bypassMem;
		else
			sel = pipePkg::bypassNone;
		return sel;
	endfunction

	assign bypassA = pickSource(deRs, emWriteAddr, emTnew, wbValid, wbAddr);
	assign bypassB = pickSource(deRt, emWriteAddr, emTnew, wbValid, wbAddr);
	assign bypassStore = pickSource(deRt, emWriteAddr, emTnew, wbValid, wbAddr);

endmodule

/* src/memStage.sv */
`timescale 1ns/1ns

module memStage #(
	parameter int dmWords = pipePkg::dmWords
) (
	input  logic              clk,
	input  logic              reset,
	input  pipePkg::kind_t    emKind,
	input  pipePkg::regAddr_t emWriteAddr,
	input  pipePkg::word_t    emResult,
	input  pipePkg::word_t    emStoreData,
	output logic              wbValid,
	output pipePkg::regAddr_t wbAddr,
	output pipePkg::word_t    wbData
);

	localparam int addrBits = $clog2(dmWords);

	pipePkg::word_t dataMem [dmWords];
	logic [addrBits-1:0] wordIndex;
	pipePkg::word_t loadWord;

	// Byte address bits 1..0 ignored, upper bits wrap
	assign wordIndex = emResult[addrBits+1:2];
	assign loadWord = dataMem[wordIndex];

	////////////////////
	// Data memory
	////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < dmWords; i++)
				dataMem[i] <= '0;
		end
		else if (emKind == pipePkg::kindSw)
		begin
			dataMem[wordIndex] <= emStoreData;
		end
	end

	////////////////////
	// Writeback register
	////////////////////

	// Stores and no-ops carry destination zero from decode
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wbValid <= 1'b0;
			wbAddr <= '0;
		end
		else
		begin
			wbValid <= (emWriteAddr != '0);
			wbAddr <= emWriteAddr;
		end
	end

	always_ff @(posedge clk)
	begin
		wbData <= (emKind == pipePkg::kindLw) ? loadWord : emResult;
	end

endmodule

/* src/pipePkg.sv */
package pipePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [2:0] tick_t;
	typedef logic [3:0] kind_t;
	typedef logic [1:0] bypass_t;

	// Instruction kinds after decode
	localparam kind_t kindNop   = 4'd0;
	localparam kind_t kindAddu  = 4'd1;
	localparam kind_t kindSubu  = 4'd2;
	localparam kind_t kindAnd   = 4'd3;
	localparam kind_t kindOr    = 4'd4;
	localparam kind_t kindXor   = 4'd5;
	localparam kind_t kindSlt   = 4'd6;
	localparam kind_t kindSll   = 4'd7;
	localparam kind_t kindAddiu = 4'd8;
	localparam kind_t kindAndi  = 4'd9;
	localparam kind_t kindOri   = 4'd10;
	localparam kind_t kindLui   = 4'd11;
	localparam kind_t kindLw    = 4'd12;
	localparam kind_t kindSw    = 4'd13;

	// Primary opcodes, bits 31..26
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opAndi    = 6'h0c;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opLui     = 6'h0f;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2b;

	// Function codes of the SPECIAL opcode
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnSlt  = 6'h2a;
	localparam logic [5:0] fnSll  = 6'h00;

	localparam bypass_t bypassNone = 2'd0;
	localparam bypass_t bypassEx   = 2'd1;
	localparam bypass_t bypassMem  = 2'd2;

	// Cycles until an operand is needed / a result is ready
	localparam tick_t tuseNone = 3'd7;
	localparam tick_t tuseEx   = 3'd1;
	localparam tick_t tnewAlu  = 3'd1;
	localparam tick_t tnewLoad = 3'd2;
	localparam tick_t tnewNone = 3'd0;

	localparam int dmWords = 64;

endpackage

/* src/pipeTop.sv */
`timescale 1ns/1ns

module pipeTop #(
	parameter int dmWords = pipePkg::dmWords
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              instrValid,
	input  pipePkg::word_t    instr,
	output logic              stall,
	output logic              wbValid,
	output pipePkg::regAddr_t wbAddr,
	output pipePkg::word_t    wbData
);

	// Incoming instruction, to hazard detection
	pipePkg::regAddr_t srcA;
	pipePkg::regAddr_t srcB;
	pipePkg::tick_t tuseA;
	pipePkg::tick_t tuseB;

	// Decode to execute
	pipePkg::kind_t deKind;
	pipePkg::regAddr_t deRs;
	pipePkg::regAddr_t deRt;
	pipePkg::regAddr_t deWriteAddr;
	logic [4:0] deShamt;
	pipePkg::word_t deImm;
	pipePkg::word_t deDataA;
	pipePkg::word_t deDataB;
	pipePkg::word_t deEarly;
	pipePkg::tick_t deTuseA;
	pipePkg::tick_t deTuseB;
	pipePkg::tick_t deTnew;

	// Execute to memory
	pipePkg::kind_t emKind;
	pipePkg::regAddr_t emWriteAddr;
	pipePkg::word_t emResult;
	pipePkg::word_t emStoreData;
	pipePkg::tick_t emTnew;

	pipePkg::bypass_t bypassA;
	pipePkg::bypass_t bypassB;
	pipePkg::bypass_t bypassStore;

	decodeStage u_decodeStage (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.stall(stall),
		.srcA(srcA),
		.srcB(srcB),
		.tuseA(tuseA),
		.tuseB(tuseB),
		.wbEnable(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.deKind(deKind),
		.deRs(deRs),
		.deRt(deRt),
		.deWriteAddr(deWriteAddr),
		.deShamt(deShamt),
		.deImm(deImm),
		.deDataA(deDataA),
		.deDataB(deDataB),
		.deEarly(deEarly),
		.deTuseA(deTuseA),
		.deTuseB(deTuseB),
		.deTnew(deTnew)
	);

	hazardUnit u_hazardUnit (
		.srcA(srcA),
		.srcB(srcB),
		.tuseA(tuseA),
		.tuseB(tuseB),
		.deRs(deRs),
		.deRt(deRt),
		.deWriteAddr(deWriteAddr),
		.deTnew(deTnew),
		.emWriteAddr(emWriteAddr),
		.emTnew(emTnew),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.stall(stall),
		.bypassA(bypassA),
		.bypassB(bypassB),
		.bypassStore(bypassStore)
	);

	executeStage u_executeStage (
		.clk(clk),
		.reset(reset),
		.deKind(deKind),
		.deRs(deRs),
		.deRt(deRt),
		.deWriteAddr(deWriteAddr),
		.deShamt(deShamt),
		.deImm(deImm),
		.deDataA(deDataA),
		.deDataB(deDataB),
		.deEarly(deEarly),
		.deTuseA(deTuseA),
		.deTuseB(deTuseB),
		.deTnew(deTnew),
		.bypassA(bypassA),
		.bypassB(bypassB),
		.bypassStore(bypassStore),
		.wbData(wbData),
		.emKind(emKind),
		.emWriteAddr(emWriteAddr),
		.emResult(emResult),
		.emStoreData(emStoreData),
		.emTnew(emTnew)
	);

	memStage #(
		.dmWords(dmWords)
	) u_memStage (
		.clk(clk),
		.reset(reset),
		.emKind(emKind),
		.emWriteAddr(emWriteAddr),
		.emResult(emResult),
		.emStoreData(emStoreData),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

endmodule

/* src/regFile.sv */
`timescale 1ns/1ns

module regFile (
	input  logic             clk,
	input  logic             reset,
	input  pipePkg::regAddr_t readAddrA,
	input  pipePkg::regAddr_t readAddrB,
	output pipePkg::word_t   readDataA,
	output pipePkg::word_t   readDataB,
	input  logic             writeEnable,
	input  pipePkg::regAddr_t writeAddr,
	input  pipePkg::word_t   writeData
);

	// Register zero has no storage
	pipePkg::word_t regs [1:31];

	// Same-cycle write is visible to the reader
	assign readDataA = (readAddrA == '0) ? '0 :
		(writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		(writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && writeAddr != '0)
		begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

/* tests/pipeTb.sv */
`timescale 1ns/1ns

module pipeTb;

	localparam int dmWords = pipePkg::dmWords;
	localparam int addrBits = $clog2(dmWords);
	localparam int instrTotal = 1500;
	localparam int cycleLimit = 3 * instrTotal + 100;
	localparam logic [31:0] lfsrTaps = 32'h80200003;

	logic clk = 1'b0;
	logic reset;
	logic instrValid;
	pipePkg::word_t instr;
	logic stall;
	logic wbValid;
	pipePkg::regAddr_t wbAddr;
	pipePkg::word_t wbData;

	int cycleCount = 0;
	int accepted = 0;
	logic [31:0] lfsrState = 32'd32;

	// Instruction currently offered to the DUT
	logic curValid;
	pipePkg::kind_t curKind;
	pipePkg::regAddr_t curRs;
	pipePkg::regAddr_t curRt;
	pipePkg::regAddr_t curRd;
	logic [4:0] curShamt;
	logic [15:0] curImm;
	pipePkg::word_t curWord;

	// Destination of a lw accepted on the previous edge or zero
	pipePkg::regAddr_t lastLoadRt = '0;

	// Architectural state
	pipePkg::word_t modelRegs [32];
	pipePkg::word_t modelMem [dmWords];

	// Expected writebacks with the oldest first
	pipePkg::regAddr_t expAddr [$];
	pipePkg::word_t expData [$];
	int expCycle [$];
	bit expLoad [$];

	pipeTop #(
		.dmWords(dmWords)
	) u_pipeTop (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.stall(stall),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			failRun($sformatf("Timeout: run not finished after %0d cycles", cycleCount));
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic failValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		failRun($sformatf("Fail %s: expected %h, actual %h", testName, expected, actual));
	endtask

	////////////////////
	// Stimulus
	////////////////////

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[30:0], lfsrState[0]};
			if (lfsrState[0])
				lfsrState = (lfsrState >> 1) ^ lfsrTaps;
			else
				lfsrState = lfsrState >> 1;
		end
		return value;
	endfunction

	function automatic pipePkg::word_t encodeWord(input pipePkg::kind_t kind,
		input pipePkg::regAddr_t rs, input pipePkg::regAddr_t rt,
		input pipePkg::regAddr_t rd, input logic [4:0] shamt, input logic [15:0] imm);
		pipePkg::word_t word;
		case (kind)
			pipePkg::kindAddu:  word = {pipePkg::opSpecial, rs, rt, rd, 5'd0, pipePkg::fnAddu};
			pipePkg::kindSubu:  word = {pipePkg::opSpecial, rs, rt, rd, 5'd0, pipePkg::fnSubu};
			pipePkg::kindAnd:   word = {pipePkg::opSpecial, rs, rt, rd, 5'd0, pipePkg::fnAnd};
			pipePkg::kindOr:    word = {pipePkg::opSpecial, rs, rt, rd, 5'd0, pipePkg::fnOr};
			pipePkg::kindXor:   word = {pipePkg::opSpecial, rs, rt, rd, 5'd0, pipePkg::fnXor};
			pipePkg::kindSlt:   word = {pipePkg::opSpecial, rs, rt, rd, 5'd0, pipePkg::fnSlt};
			pipePkg::kindSll:   word = {pipePkg::opSpecial, rs, rt, rd, shamt, pipePkg::fnSll};
			pipePkg::kindAddiu: word = {pipePkg::opAddiu, rs, rt, imm};
			pipePkg::kindAndi:  word = {pipePkg::opAndi, rs, rt, imm};
			pipePkg::kindOri:   word = {pipePkg::opOri, rs, rt, imm};
			pipePkg::kindLui:   word = {pipePkg::opLui, rs, rt, imm};
			pipePkg::kindLw:    word = {pipePkg::opLw, rs, rt, imm};
			pipePkg::kindSw:    word = {pipePkg::opSw, rs, rt, imm};
			default:            word = '0;
		endcase
		return word;
	endfunction

	task automatic pickInstruction();
		logic [3:0] choice;
		curValid = (randBits(4) < 13);
		choice = 4'(randBits(4));
		curRs = 5'(randBits(3));
		curRt = 5'(randBits(3));
		curRd = 5'(randBits(3));
		curShamt = 5'(randBits(5));
		curImm = 16'(randBits(16));
		case (choice)
			4'd0:        curKind = pipePkg::kindAddu;
			4'd1:        curKind = pipePkg::kindSubu;
			4'd2:        curKind = pipePkg::kindAnd;
			4'd3:        curKind = pipePkg::kindOr;
			4'd4:        curKind = pipePkg::kindXor;
			4'd5:        curKind = pipePkg::kindSlt;
			4'd6:        curKind = pipePkg::kindSll;
			4'd7:        curKind = pipePkg::kindAddiu;
			4'd8:        curKind = pipePkg::kindAndi;
			4'd9:        curKind = pipePkg::kindOri;
			4'd10:       curKind = pipePkg::kindLui;
			4'd11, 4'd12: curKind = pipePkg::kindLw;
			4'd13, 4'd14: curKind = pipePkg::kindSw;
			default:     curKind = pipePkg::kindNop;
		endcase
		if (curKind == pipePkg::kindSll || curKind == pipePkg::kindLui)
			curRs = '0;
		// Memory accesses use base zero and stay inside the memory
		if (curKind == pipePkg::kindLw || curKind == pipePkg::kindSw)
		begin
			curRs = '0;
			curImm = 16'(randBits(addrBits) << 2);
		end
		curWord = encodeWord(curKind, curRs, curRt, curRd, curShamt, curImm);
		// Undefined words are a jump or SPECIAL with an unused function
		if (choice == 4'd15)
		begin
			if (randBits(1) == 1)
				curWord = {6'h02, 26'(randBits(26))};
			else
				curWord = {pipePkg::opSpecial, curRs, curRt, curRd, 5'd0, 6'h08};
		end
	endtask

	////////////////////
	// Model
	////////////////////

	function automatic logic readsReg(input pipePkg::kind_t kind, input pipePkg::regAddr_t rs,
		input pipePkg::regAddr_t rt, input pipePkg::regAddr_t r);
		logic hit;
		case (kind)
			pipePkg::kindAddu, pipePkg::kindSubu, pipePkg::kindAnd, pipePkg::kindOr,
			pipePkg::kindXor, pipePkg::kindSlt, pipePkg::kindSw:
				hit = (rs == r) || (rt == r);
			pipePkg::kindSll:
				hit = (rt == r);
			pipePkg::kindAddiu, pipePkg::kindAndi, pipePkg::kindOri, pipePkg::kindLw:
				hit = (rs == r);
			default:
				hit = 1'b0;
		endcase
		return hit;
	endfunction

	task automatic modelExecute(input int stamp);
		pipePkg::word_t a;
		pipePkg::word_t b;
		pipePkg::word_t result;
		pipePkg::word_t addr;
		pipePkg::regAddr_t dest;
		int index;
		a = modelRegs[curRs];
		b = modelRegs[curRt];
		addr = a + {{16{curImm[15]}}, curImm};
		index = (addr >> 2) % dmWords;
		case (curKind)
			pipePkg::kindAddu:  result = a + b;
			pipePkg::kindSubu:  result = a - b;
			pipePkg::kindAnd:   result = a & b;
			pipePkg::kindOr:    result = a | b;
			pipePkg::kindXor:   result = a ^ b;
			pipePkg::kindSlt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			pipePkg::kindSll:   result = b << curShamt;
			pipePkg::kindAddiu: result = addr;
			pipePkg::kindAndi:  result = a & {16'h0000, curImm};
			pipePkg::kindOri:   result = a | {16'h0000, curImm};
			pipePkg::kindLui:   result = {curImm, 16'h0000};
			pipePkg::kindLw:    result = modelMem[index];
			default:            result = '0;
		endcase
		case (curKind)
			pipePkg::kindAddu, pipePkg::kindSubu, pipePkg::kindAnd, pipePkg::kindOr,
			pipePkg::kindXor, pipePkg::kindSlt, pipePkg::kindSll:
				dest = curRd;
			pipePkg::kindAddiu, pipePkg::kindAndi, pipePkg::kindOri,
			pipePkg::kindLui, pipePkg::kindLw:
				dest = curRt;
			default:
				dest = '0;
		endcase
		if (curKind == pipePkg::kindSw)
			modelMem[index] = b;
		// Register zero writes are dropped
		if (dest != '0)
		begin
			modelRegs[dest] = result;
			expAddr.push_back(dest);
			expData.push_back(result);
			expCycle.push_back(stamp);
			expLoad.push_back(curKind == pipePkg::kindLw);
		end
	endtask

	////////////////////
	// Checks
	////////////////////

	task automatic checkIdle(input string phase);
		assert (wbValid == 1'b0)
			else failValue({phase, " wbValid"}, 32'd0, 32'(wbValid));
		assert (stall == 1'b0)
			else failValue({phase, " stall"}, 32'd0, 32'(stall));
	endtask

	task automatic checkWriteback();
		string testName;
		if (wbValid)
		begin
			assert (expAddr.size() != 0)
				else failRun("Writeback appeared with no instruction outstanding");
			testName = expLoad[0] ? "load data" : "ALU result";
			assert (expCycle[0] + 2 == cycleCount)
				else failValue("writeback latency", expCycle[0] + 2, cycleCount);
			assert (wbAddr == expAddr[0])
				else failValue("writeback address", 32'(expAddr[0]), 32'(wbAddr));
			assert (wbData == expData[0])
				else failValue(testName, expData[0], wbData);
			void'(expAddr.pop_front());
			void'(expData.pop_front());
			void'(expCycle.pop_front());
			void'(expLoad.pop_front());
		end
		else if (expAddr.size() != 0)
		begin
			assert (expCycle[0] + 2 > cycleCount)
				else failRun("Expected writeback did not appear on time");
		end
	endtask

	// Load-use stall when the previous accepted lw writes a register this one reads
	task automatic checkStall();
		logic expectStall;
		expectStall = instrValid && (lastLoadRt != '0) &&
			readsReg(curKind, curRs, curRt, lastLoadRt);
		assert (stall == expectStall)
			else failValue("stall", 32'(expectStall), 32'(stall));
	endtask

	// Decides what the coming edge does and what is offered next
	task automatic stepDriver();
		if (instrValid && !stall)
		begin
			modelExecute(cycleCount + 1);
			accepted++;
			lastLoadRt = (curKind == pipePkg::kindLw) ? curRt : '0;
			if (accepted < instrTotal)
				pickInstruction();
			else
				curValid = 1'b0;
		end
		else
		begin
			lastLoadRt = '0;
			if (!instrValid && accepted < instrTotal)
				pickInstruction();
		end
	endtask

	initial
	begin
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < dmWords; i++)
			modelMem[i] = '0;

		repeat (3)
		begin
			@(posedge clk);
			@(negedge clk);
			checkIdle("reset");
		end
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkIdle("after reset");
		pickInstruction();

		while (!(accepted == instrTotal && expAddr.size() == 0))
		begin
			@(posedge clk);
			instrValid <= curValid;
			instr <= curWord;
			@(negedge clk);
			checkWriteback();
			checkStall();
			stepDriver();
		end

		// Nothing more may come out once drained
		repeat (4)
		begin
			@(posedge clk);
			instrValid <= 1'b0;
			@(negedge clk);
			checkWriteback();
			checkStall();
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
